// ==== rtl/frame_rd_pkg.sv ====
////////////////////
// frame read arbiter shared sizes, region bases,
// region and beat types, sequencer states, port structs
////////////////////
`default_nettype none

package frame_rd_pkg;

    // ddr geometry
    localparam int ROW_W  = 15;
    localparam int BANK_W = 3;
    localparam int COL_W  = 10;
    localparam int ADDR_W = ROW_W + BANK_W + COL_W;
    localparam int DATA_W = 64;   // scaled down word

    localparam int BURST_LEN   = 4;
    localparam int QUAD_BURSTS = 3;   // bursts per quarter frame
    localparam int WIDE_BURSTS = 6;   // bursts per wide frame
    localparam int NUM_REGIONS = 5;
    localparam int PTR_W       = $clog2(WIDE_BURSTS * BURST_LEN);

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [2:0]                   region_t;
    typedef logic [$clog2(BURST_LEN)-1:0] beat_t;
    typedef logic [PTR_W-1:0]             ptr_t;

    localparam addr_t FRAME_OFFSET = addr_t'(1024);

    // two frame buffers per region
    localparam addr_t REGION_BASE [NUM_REGIONS] = '{
        addr_t'(0),
        addr_t'(2 * 1024),
        addr_t'(4 * 1024),
        addr_t'(6 * 1024),
        addr_t'(8 * 1024)
    };

    localparam region_t QUAD_LAST_REGION = 3'd3;
    localparam region_t WIDE_REGION      = 3'd4;

    // pointer value of the final burst in a frame
    localparam ptr_t PTR_STEP      = ptr_t'(BURST_LEN);
    localparam ptr_t QUAD_LAST_PTR = ptr_t'((QUAD_BURSTS - 1) * BURST_LEN);
    localparam ptr_t WIDE_LAST_PTR = ptr_t'((WIDE_BURSTS - 1) * BURST_LEN);

    typedef enum logic [1:0] {
        ST_SETUP,   // address register settles
        ST_ADDR,
        ST_DATA,
        ST_HOLD     // paused on buffer wait
    } seq_state_e;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ar_req_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [DATA_W-1:0] data;
    } r_beat_t;

    typedef struct packed {
        logic              en;
        region_t           region;
        beat_t             beat;
        logic [DATA_W-1:0] data;
    } buf_wr_t;

endpackage

`default_nettype wire

// ==== rtl/view_sequencer.sv ====
////////////////////
// view_sequencer: region rotation and
// address/data FSM with buffer wait pause
////////////////////
`timescale 1ns/1ps
`default_nettype none

module view_sequencer (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             wide_mode,
    input  wire logic             buf_wait,
    input  wire logic             ar_ready,
    input  wire logic             burst_done,
    output logic                  ar_valid,
    output logic                  addr_accept,
    output frame_rd_pkg::region_t cur_region
);
    import frame_rd_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    region_t    region_q;
    region_t    start_region;
    region_t    next_region;
    logic       first_q;      // still on the region chosen at reset
    logic       round_end;

    // first region follows the mode until the first clock after reset
    assign start_region = wide_mode ? WIDE_REGION : region_t'(0);
    assign cur_region   = first_q ? start_region : region_q;

    // a full round ends after region 3 or after every wide burst
    assign round_end = (region_q == QUAD_LAST_REGION) || (region_q == WIDE_REGION);

    always_comb begin
        if (wide_mode) begin
            next_region = WIDE_REGION;
        end else if (round_end) begin
            next_region = region_t'(0);   // back to the top-left quarter
        end else begin
            next_region = region_t'(region_q + 1'b1);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_SETUP: begin
                state_d = ST_ADDR;
            end
            ST_ADDR: begin
                if (ar_ready) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA: begin
                if (burst_done) begin
                    state_d = (round_end && buf_wait) ? ST_HOLD : ST_SETUP;
                end
            end
            ST_HOLD: begin
                if (!buf_wait) begin
                    state_d = ST_SETUP;
                end
            end
            default: state_d = ST_SETUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q  <= ST_SETUP;
            region_q <= '0;
            first_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            if (first_q) begin
                region_q <= start_region;
                first_q  <= 1'b0;
            end else if ((state_q == ST_DATA) && burst_done) begin
                region_q <= next_region;   // mode sampled here only
            end
        end
    end

    assign ar_valid    = (state_q == ST_ADDR);
    assign addr_accept = ar_valid && ar_ready;

endmodule

`default_nettype wire

// ==== rtl/region_addr_gen.sv ====
////////////////////
// region_addr_gen: per region burst pointer,
// ping-pong frame bit and registered burst address
////////////////////
`timescale 1ns/1ps
`default_nettype none

module region_addr_gen (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire frame_rd_pkg::region_t  cur_region,
    input  wire logic                   addr_accept,
    output frame_rd_pkg::addr_t         ar_addr
);
    import frame_rd_pkg::*;

    ptr_t                   ptr_q [NUM_REGIONS];
    logic [NUM_REGIONS-1:0] frame_q;   // set means second buffer

    ptr_t  sel_ptr;
    ptr_t  last_ptr;
    logic  sel_frame;
    addr_t sel_base;
    addr_t frame_add;

    // pick the state of the region being served
    always_comb begin
        sel_ptr   = '0;
        sel_frame = 1'b0;
        sel_base  = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (cur_region == region_t'(i)) begin
                sel_ptr   = ptr_q[i];
                sel_frame = frame_q[i];
                sel_base  = REGION_BASE[i];
            end
        end
    end

    // wide region has a longer frame
    assign last_ptr  = (cur_region == WIDE_REGION) ? WIDE_LAST_PTR : QUAD_LAST_PTR;
    assign frame_add = sel_frame ? FRAME_OFFSET : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                ptr_q[i] <= '0;
            end
            frame_q <= '0;
        end else if (addr_accept) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                if (cur_region == region_t'(i)) begin
                    if (sel_ptr == last_ptr) begin
                        ptr_q[i]   <= '0;            // frame done
                        frame_q[i] <= ~frame_q[i];   // swap buffers
                    end else begin
                        ptr_q[i] <= sel_ptr + PTR_STEP;
                    end
                end
            end
        end
    end

    // follows cur_region one cycle later, the setup cycle covers this
    always_ff @(posedge clk) begin
        ar_addr <= sel_base + frame_add + addr_t'(sel_ptr);
    end

endmodule

`default_nettype wire

// ==== rtl/burst_to_buf.sv ====
////////////////////
// burst_to_buf: returned beats to tagged
// buffer writes, end of burst flag
////////////////////
`timescale 1ns/1ps
`default_nettype none

module burst_to_buf (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire frame_rd_pkg::r_beat_t  r,
    input  wire frame_rd_pkg::region_t  cur_region,
    output frame_rd_pkg::buf_wr_t       buf_wr,
    output logic                        burst_done
);
    import frame_rd_pkg::*;

    beat_t             beat_q;      // position of the next beat
    logic              wr_en_q;
    region_t           wr_region_q;
    beat_t             wr_beat_q;
    logic [DATA_W-1:0] wr_data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat_q     <= '0;
            wr_en_q    <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            wr_en_q    <= r.valid;
            burst_done <= r.valid && r.last;   // lines up with last write
            if (r.valid) begin
                beat_q <= r.last ? beat_t'(0) : beat_t'(beat_q + 1'b1);
            end
        end
    end

    // payload only moves on a beat
    always_ff @(posedge clk) begin
        if (r.valid) begin
            wr_region_q <= cur_region;
            wr_beat_q   <= beat_q;
            wr_data_q   <= r.data;
        end
    end

    assign buf_wr = '{en: wr_en_q, region: wr_region_q, beat: wr_beat_q, data: wr_data_q};

endmodule

`default_nettype wire

// ==== rtl/frame_rd_arbiter.sv ====
////////////////////
// frame_rd_arbiter: top level, sequencer,
// address generator and buffer writer
////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_rd_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   wide_mode,
    input  wire logic                   buf_wait,
    output frame_rd_pkg::ar_req_t       ar,
    input  wire logic                   ar_ready,
    input  wire frame_rd_pkg::r_beat_t  r,
    output frame_rd_pkg::buf_wr_t       buf_wr
);
    import frame_rd_pkg::*;

    logic    ar_valid;
    logic    addr_accept;
    logic    burst_done;
    region_t cur_region;
    addr_t   ar_addr;

    view_sequencer seq_i (
        .clk         (clk),
        .rst         (rst),
        .wide_mode   (wide_mode),
        .buf_wait    (buf_wait),
        .ar_ready    (ar_ready),
        .burst_done  (burst_done),
        .ar_valid    (ar_valid),
        .addr_accept (addr_accept),
        .cur_region  (cur_region)
    );

    region_addr_gen addr_i (
        .clk         (clk),
        .rst         (rst),
        .cur_region  (cur_region),
        .addr_accept (addr_accept),
        .ar_addr     (ar_addr)
    );

    burst_to_buf wr_i (
        .clk        (clk),
        .rst        (rst),
        .r          (r),
        .cur_region (cur_region),
        .buf_wr     (buf_wr),
        .burst_done (burst_done)
    );

    // id, len, size and burst type are tied outside
    assign ar = '{valid: ar_valid, addr: ar_addr};

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
////////////////////
// testbench clock source, 8 ns period
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;   // half period
        end
    end
endmodule

`default_nettype wire

// ==== dv/ddr_rd_model.sv ====
////////////////////
// ddr read responder: random accept delay,
// random data gaps, address tagged data
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ddr_rd_model (
    input  wire logic                  clk,
    input  wire frame_rd_pkg::ar_req_t ar,
    output logic                       ar_ready,
    output frame_rd_pkg::r_beat_t      r
);
    import frame_rd_pkg::*;

    addr_t       acc_addr;
    int unsigned delay;

    // 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(32'h4b6b));
        ar_ready = 1'b0;
        r        = '0;
        forever begin
            next_cycle();
            if (ar.valid === 1'b1) begin
                delay = $urandom_range(3, 0);
                repeat (delay) next_cycle();
                ar_ready = 1'b1;
                acc_addr = ar.addr;   // held stable while valid
                next_cycle();
                ar_ready = 1'b0;
                for (int b = 0; b < BURST_LEN; b++) begin
                    if ($urandom_range(1, 0) == 1) begin
                        next_cycle();   // idle cycle on the data bus
                    end
                    r.valid = 1'b1;
                    r.last  = (b == BURST_LEN - 1);
                    r.data  = DATA_W'({acc_addr, beat_t'(b)});
                    next_cycle();
                    r = '0;
                end
            end
        end
    end
endmodule

`default_nettype wire

// ==== dv/frame_rd_tb.sv ====
////////////////////
// frame read arbiter testbench: stimulus,
// reference model, checks, watchdog, report
////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_rd_tb;
    import frame_rd_pkg::*;

    localparam int QUAD_RUN     = 26;   // two frame swaps per quarter
    localparam int SETTLE_RUN   = 4;
    localparam int WIDE_RUN     = 14;   // two wide frames after the switch
    localparam int END_RUN      = 6;
    localparam int PAUSE_BURSTS = 4;    // at most one round before a hold
    localparam int EXP_BURSTS   = QUAD_RUN + SETTLE_RUN + WIDE_RUN + END_RUN
                                + 2 * PAUSE_BURSTS;
    localparam int WATCHDOG_NS  = 2 * EXP_BURSTS * 20 * 8;

    logic                   clk;
    logic                   rst;
    logic                   wide_mode;
    logic                   buf_wait;
    logic                   ar_ready;
    ar_req_t                ar;
    r_beat_t                r;
    buf_wr_t                buf_wr;
    int                     ref_ptr [NUM_REGIONS] = '{default: 0};
    logic [NUM_REGIONS-1:0] ref_frame = '0;
    logic [NUM_REGIONS-1:0] seen_frame = '0;   // frame bit last shown on ar.addr
    logic                   addr_frame;
    int                     wraps [NUM_REGIONS] = '{default: 0};
    region_t                exp_region;
    addr_t                  exp_addr;
    beat_t                  exp_beat;
    logic                   rst_seen = 1'b0;
    logic                   beat_seen;
    logic                   last_seen;     // burst_done due next cycle
    logic [DATA_W-1:0]      beat_data;
    logic                   round_end;
    logic                   hold_active = 1'b0;
    int                     start_cnt;     // cycles until ar.valid must rise
    int                     frame_bursts;
    int                     bursts_done = 0;
    int                     checks [1:5] = '{default: 0};
    int                     errors [1:5] = '{default: 0};
    int                     total_chk = 0;
    int                     total_err = 0;

    tb_clk_gen clk_gen_i (.clk(clk));

    frame_rd_arbiter dut_i (
        .clk       (clk),
        .rst       (rst),
        .wide_mode (wide_mode),
        .buf_wait  (buf_wait),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r         (r),
        .buf_wr    (buf_wr)
    );

    ddr_rd_model mem_i (.clk(clk), .ar(ar), .ar_ready(ar_ready), .r(r));

    task automatic verify(input int idx, input logic ok, input string msg);
        checks[idx]++;
        assert (ok) else begin
            errors[idx]++;
            $display("FAIL t=%0t %s", $time, msg);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_bursts(input int n);
        int target;
        target = bursts_done + n;
        while (bursts_done < target) next_cycle();
    endtask

    // hold buf_wait until the arbiter has paused for a while
    task automatic pause_round(input int hold_cycles);
        buf_wait = 1'b1;
        while (!hold_active) next_cycle();
        repeat (hold_cycles) next_cycle();
        buf_wait = 1'b0;
    endtask

    // outputs sampled on the falling edge
    always @(negedge clk) begin
        if (!rst || !rst_seen) begin
            verify(1, ar.valid === 1'b0 && buf_wr.en === 1'b0,
                   "ar.valid or buf_wr.en not low in reset");
            exp_region = wide_mode ? 3'd4 : 3'd0;
            exp_beat   = '0;
            beat_seen  = 1'b0;
            last_seen  = 1'b0;
            start_cnt  = 0;
        end else begin
            if (hold_active && buf_wait) begin
                verify(5, !ar.valid, "ar.valid high while held on buf_wait");
            end
            hold_active = hold_active && buf_wait;
            if (start_cnt == 1) begin
                verify(5, ar.valid, "no address request two cycles after burst end");
            end
            start_cnt = (start_cnt > 0) ? start_cnt - 1 : 0;
            verify(4, buf_wr.en == beat_seen, "buf_wr.en does not follow the data beat");
            if (beat_seen) begin
                verify(4, buf_wr.data == beat_data && buf_wr.beat == exp_beat,
                       $sformatf("write %h beat %0d, expected %h beat %0d",
                                 buf_wr.data, buf_wr.beat, beat_data, exp_beat));
                verify(3, buf_wr.region == exp_region,
                       $sformatf("write region %0d, expected %0d", buf_wr.region, exp_region));
                exp_beat = last_seen ? beat_t'(0) : exp_beat + 1'b1;
            end
            if (last_seen) begin   // next region chosen at this edge
                bursts_done++;
                round_end   = (exp_region == 3'd3) || (exp_region == 3'd4);
                hold_active = round_end && buf_wait;
                start_cnt   = hold_active ? 0 : 2;
                exp_region  = wide_mode ? 3'd4 : (round_end ? 3'd0 : exp_region + 3'd1);
            end
            if (ar.valid && ar_ready) begin
                exp_addr = REGION_BASE[exp_region] + addr_t'(ref_ptr[exp_region])
                         + (ref_frame[exp_region] ? FRAME_OFFSET : addr_t'(0));
                verify(2, ar.addr == exp_addr,
                       $sformatf("region %0d address %h, expected %h",
                                 exp_region, ar.addr, exp_addr));
                addr_frame = (ar.addr & FRAME_OFFSET) != addr_t'(0);
                if (addr_frame != seen_frame[exp_region]) begin   // dut swapped buffers
                    seen_frame[exp_region] = addr_frame;
                    wraps[exp_region]++;
                end
                frame_bursts = (exp_region == 3'd4) ? WIDE_BURSTS : QUAD_BURSTS;
                if (ref_ptr[exp_region] == (frame_bursts - 1) * BURST_LEN) begin
                    ref_ptr[exp_region]   = 0;
                    ref_frame[exp_region] = ~ref_frame[exp_region];
                end else begin
                    ref_ptr[exp_region] += BURST_LEN;
                end
            end
            beat_seen = r.valid;
            last_seen = r.valid && r.last;
            beat_data = r.data;
        end
        rst_seen = rst;
    end

    initial begin
        rst       = 1'b0;
        wide_mode = 1'b0;
        buf_wait  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        run_bursts(QUAD_RUN);
        pause_round(12);
        run_bursts(SETTLE_RUN);
        wide_mode = 1'b1;
        run_bursts(WIDE_RUN);
        pause_round(12);
        wide_mode = 1'b0;
        run_bursts(END_RUN);
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (wraps[i] < 2) begin
                errors[2]++;
                $display("region %0d swapped frame buffers only %0d times", i, wraps[i]);
            end
        end
        for (int i = 1; i <= 5; i++) begin
            $display("behavior %0d: %0d checks, %0d errors", i, checks[i], errors[i]);
            total_chk += checks[i];
            total_err += errors[i];
        end
        $display("total: %0d checks, %0d errors, %0d bursts", total_chk, total_err, bursts_done);
        if (total_err == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/frame_rd_pkg.sv
rtl/view_sequencer.sv
rtl/region_addr_gen.sv
rtl/burst_to_buf.sv
rtl/frame_rd_arbiter.sv
dv/tb_clk_gen.sv
dv/ddr_rd_model.sv
dv/frame_rd_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the frame read arbiter
TOP := frame_rd_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log
